// ==== rtl/prbs_link_pkg.sv ====
package prbs_link_pkg;

    ////////////////////////////////////////////////////////////////////
    // Widths and basic vector types
    ////////////////////////////////////////////////////////////////////

    // Fiber lanes on the board
    localparam int N_LANES = 8;

    // One bit per lane
    typedef logic [N_LANES-1:0] lane_mask_t;
    // CCB command code
    typedef logic [5:0]         ccb_cmd_t;
    // Phase code shown on the upper LED nibble
    typedef logic [3:0]         phase_code_t;
    // Boot phase timer in clk40 cycles
    typedef logic [7:0]         timer_t;
    // Front-panel LED byte
    typedef logic [7:0]         led_t;

    // Decoded CCB commands
    localparam ccb_cmd_t CMD_BX0     = 6'h01;
    localparam ccb_cmd_t CMD_RESYNC  = 6'h03;
    localparam ccb_cmd_t CMD_BXRESET = 6'h32;

    // Boot timer thresholds
    localparam timer_t T_TX_EN       = 8'd20;
    localparam timer_t T_RX_EN       = 8'd40;
    localparam timer_t T_INJECT_END  = 8'd140;
    localparam timer_t T_CLEAR_START = 8'd160;
    localparam timer_t T_CHECK_START = 8'd180;

    // LED phase codes
    localparam phase_code_t PH_RESET        = 4'b0001;
    localparam phase_code_t PH_EN_TX        = 4'b0010;
    localparam phase_code_t PH_TX_DONE      = 4'b0011;
    localparam phase_code_t PH_EN_RX        = 4'b0100;
    localparam phase_code_t PH_RX_DONE      = 4'b0101;
    localparam phase_code_t PH_INJECT       = 4'b0110;
    localparam phase_code_t PH_INJECT_DONE  = 4'b1000;
    localparam phase_code_t PH_INJECT_CLEAR = 4'b0111;
    localparam phase_code_t PH_CHECK        = 4'b1111;

    ////////////////////////////////////////////////////////////////////
    // Boot sequencer states
    ////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        ST_RESET             = 4'd0,
        ST_EN_TX             = 4'd1,
        ST_EN_TX_DONE        = 4'd2,
        ST_EN_RX             = 4'd3,
        ST_EN_RX_DONE        = 4'd4,
        ST_PRBS_INJECT       = 4'd5,
        ST_PRBS_INJECT_DONE  = 4'd6,
        ST_PRBS_INJECT_CLEAR = 4'd7,
        ST_EN_PRBS_CK        = 4'd8
    } boot_state_t;

    ////////////////////////////////////////////////////////////////////
    // Structs passed between stages
    ////////////////////////////////////////////////////////////////////

    // Raw CCB bus as it arrives, all fields active low
    typedef struct packed {
        logic     strobe_n;
        ccb_cmd_t cmd_n;
    } ccb_rx_t;

    // One-cycle decoded CCB events
    typedef struct packed {
        logic bx0_pulse;
        logic resync;
        logic bxreset;
    } ccb_evt_t;

    // Sequencer controls toward the transceivers and the LED logic
    typedef struct packed {
        logic        tx_reset;
        logic        rx_reset;
        logic        err_clear;
        logic        error_inject;
        logic        show_errors;
        phase_code_t phase;
    } boot_ctrl_t;

endpackage

// ==== rtl/ccb_cmd_decoder.sv ====
`timescale 1ns/10ps

module ccb_cmd_decoder (
    input  logic                   clk40,
    input  logic                   PRBS_reset,
    input  prbs_link_pkg::ccb_rx_t ccb_rx_i,
    output prbs_link_pkg::ccb_evt_t ccb_evt_o
);

    import prbs_link_pkg::*;

    ////////////////////////////////////////////////////////////////////
    // Stage 1  bus capture
    ////////////////////////////////////////////////////////////////////

    // Raw active-low bus, idles at all ones
    ccb_rx_t  ccb_raw_q;
    // Active-high view of the captured bus
    logic     cmd_strobe;
    ccb_cmd_t cmd_code;

    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            ccb_raw_q <= '1;
        end else begin
            ccb_raw_q <= ccb_rx_i;
        end
    end

    // Undo the bus polarity
    assign cmd_strobe = ~ccb_raw_q.strobe_n;
    assign cmd_code   = ~ccb_raw_q.cmd_n;

    ////////////////////////////////////////////////////////////////////
    // Stage 2  command compare
    ////////////////////////////////////////////////////////////////////

    logic bx0_lvl_q;
    logic resync_q;
    logic bxreset_q;
    // Previous bx0 level for the edge detect
    logic bx0_lvl_d1_q;

    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            bx0_lvl_q <= 1'b0;
            resync_q  <= 1'b0;
            bxreset_q <= 1'b0;
        end else begin
            // Only a strobed command counts
            bx0_lvl_q <= cmd_strobe && (cmd_code == CMD_BX0);
            resync_q  <= cmd_strobe && (cmd_code == CMD_RESYNC);
            bxreset_q <= cmd_strobe && (cmd_code == CMD_BXRESET);
        end
    end

    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            bx0_lvl_d1_q <= 1'b0;
        end else begin
            bx0_lvl_d1_q <= bx0_lvl_q;
        end
    end

    // Held bx0 gives a single pulse on its rising edge
    assign ccb_evt_o.bx0_pulse = bx0_lvl_q & ~bx0_lvl_d1_q;
    // Levels follow the captured command
    assign ccb_evt_o.resync    = resync_q;
    assign ccb_evt_o.bxreset   = bxreset_q;

    // Two distinct codes can never decode from one capture
    a_evt_exclusive : assert property (
        @(posedge clk40) disable iff (PRBS_reset)
        !(ccb_evt_o.resync && ccb_evt_o.bxreset)
    );

endmodule

// ==== rtl/link_boot_fsm.sv ====
`timescale 1ns/10ps

module link_boot_fsm (
    input  logic                      clk40,
    input  logic                      PRBS_reset,
    input  prbs_link_pkg::ccb_evt_t   ccb_evt_i,
    input  logic                      inject_i,
    input  prbs_link_pkg::lane_mask_t tx_reset_done_i,
    input  prbs_link_pkg::lane_mask_t rx_reset_done_i,
    output prbs_link_pkg::boot_ctrl_t boot_ctrl_o
);

    import prbs_link_pkg::*;

    boot_state_t state_q;
    boot_state_t state_d;
    timer_t      timer_q;
    // Timer is held at zero in the reset and wait-for-done states
    logic        timer_clr;
    // All lanes report done
    logic        tx_all_done;
    logic        rx_all_done;

    assign tx_all_done = &tx_reset_done_i;
    assign rx_all_done = &rx_reset_done_i;

    ////////////////////////////////////////////////////////////////////
    // State and timer registers
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            state_q <= ST_RESET;
        end else begin
            state_q <= state_d;
        end
    end

    assign timer_clr = (state_q == ST_RESET)      ||
                       (state_q == ST_EN_TX_DONE) ||
                       (state_q == ST_EN_RX_DONE);

    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            timer_q <= '0;
        end else if (timer_clr) begin
            timer_q <= '0;
        end else begin
            // Wraps harmlessly in the check state
            timer_q <= timer_q + 8'd1;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_RESET: begin
                state_d = ST_EN_TX;
            end
            ST_EN_TX: begin
                if (timer_q >= T_TX_EN) begin
                    state_d = ST_EN_TX_DONE;
                end
            end
            ST_EN_TX_DONE: begin
                if (tx_all_done) begin
                    state_d = ST_EN_RX;
                end
            end
            ST_EN_RX: begin
                if (timer_q >= T_RX_EN) begin
                    state_d = ST_EN_RX_DONE;
                end
            end
            ST_EN_RX_DONE: begin
                if (rx_all_done) begin
                    state_d = ST_PRBS_INJECT;
                end
            end
            ST_PRBS_INJECT: begin
                if (timer_q >= T_INJECT_END) begin
                    state_d = ST_PRBS_INJECT_DONE;
                end
            end
            ST_PRBS_INJECT_DONE: begin
                if (timer_q >= T_CLEAR_START) begin
                    state_d = ST_PRBS_INJECT_CLEAR;
                end
            end
            ST_PRBS_INJECT_CLEAR: begin
                if (timer_q >= T_CHECK_START) begin
                    state_d = ST_EN_PRBS_CK;
                end
            end
            // Check state holds until a resync
            ST_EN_PRBS_CK: begin
                state_d = ST_EN_PRBS_CK;
            end
            default: begin
                state_d = ST_RESET;
            end
        endcase
        // Resync restarts the whole sequence from any state
        if (ccb_evt_i.resync) begin
            state_d = ST_RESET;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        boot_ctrl_o = '0;
        case (state_q)
            ST_RESET: begin
                boot_ctrl_o.tx_reset = 1'b1;
                boot_ctrl_o.rx_reset = 1'b1;
                boot_ctrl_o.phase    = PH_RESET;
            end
            ST_EN_TX: begin
                // TX out of reset, RX still held
                boot_ctrl_o.rx_reset = 1'b1;
                boot_ctrl_o.phase    = PH_EN_TX;
            end
            ST_EN_TX_DONE: begin
                boot_ctrl_o.rx_reset = 1'b1;
                boot_ctrl_o.phase    = PH_TX_DONE;
            end
            ST_EN_RX: begin
                boot_ctrl_o.phase = PH_EN_RX;
            end
            ST_EN_RX_DONE: begin
                // Forced errors start while RX locks
                boot_ctrl_o.error_inject = 1'b1;
                boot_ctrl_o.phase        = PH_RX_DONE;
            end
            ST_PRBS_INJECT: begin
                boot_ctrl_o.error_inject = 1'b1;
                boot_ctrl_o.show_errors  = 1'b1;
                boot_ctrl_o.phase        = PH_INJECT;
            end
            ST_PRBS_INJECT_DONE: begin
                // Injected errors are wiped here
                boot_ctrl_o.error_inject = 1'b1;
                boot_ctrl_o.err_clear    = 1'b1;
                boot_ctrl_o.show_errors  = 1'b1;
                boot_ctrl_o.phase        = PH_INJECT_DONE;
            end
            ST_PRBS_INJECT_CLEAR: begin
                boot_ctrl_o.show_errors = 1'b1;
                boot_ctrl_o.phase       = PH_INJECT_CLEAR;
            end
            ST_EN_PRBS_CK: begin
                // Operator inject or a bx0 forces one error
                boot_ctrl_o.error_inject = inject_i | ccb_evt_i.bx0_pulse;
                boot_ctrl_o.err_clear    = ccb_evt_i.bxreset;
                boot_ctrl_o.show_errors  = 1'b1;
                boot_ctrl_o.phase        = PH_CHECK;
            end
            default: begin
                boot_ctrl_o.tx_reset = 1'b1;
                boot_ctrl_o.rx_reset = 1'b1;
                boot_ctrl_o.phase    = PH_RESET;
            end
        endcase
    end

    // RX must never leave reset before TX
    a_tx_before_rx : assert property (
        @(posedge clk40) disable iff (PRBS_reset)
        boot_ctrl_o.tx_reset |-> boot_ctrl_o.rx_reset
    );

    a_state_legal : assert property (
        @(posedge clk40) disable iff (PRBS_reset)
        state_q inside {[ST_RESET:ST_EN_PRBS_CK]}
    );

endmodule

// ==== rtl/prbs_error_monitor.sv ====
`timescale 1ns/10ps

module prbs_error_monitor (
    input  logic                      clk40,
    input  logic                      PRBS_reset,
    input  prbs_link_pkg::boot_ctrl_t boot_ctrl_i,
    input  prbs_link_pkg::lane_mask_t prbs_error_i,
    output prbs_link_pkg::lane_mask_t latched_error_o,
    output prbs_link_pkg::led_t       led_o
);

    import prbs_link_pkg::*;

    // Sticky per-lane error flags
    lane_mask_t err_latch_q;
    // Lanes 7..4 as seen on the panel
    logic [3:0] led_err;

    ////////////////////////////////////////////////////////////////////
    // Sticky latch
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            err_latch_q <= '0;
        end else if (boot_ctrl_i.err_clear) begin
            // Clear wins over new errors in the same cycle
            err_latch_q <= '0;
        end else begin
            err_latch_q <= err_latch_q | prbs_error_i;
        end
    end

    assign latched_error_o = err_latch_q;

    ////////////////////////////////////////////////////////////////////
    // LED byte
    ////////////////////////////////////////////////////////////////////

    // Blank the error nibble until the sequencer enables it
    assign led_err = boot_ctrl_i.show_errors ? err_latch_q[7:4] : 4'b0000;
    assign led_o   = {boot_ctrl_i.phase, led_err};

    // After a lone clear the mask rebuilds from the following cycle only
    a_clear_restart : assert property (
        @(posedge clk40) disable iff (PRBS_reset)
        (boot_ctrl_i.err_clear ##1 !boot_ctrl_i.err_clear)
            |=> (err_latch_q == $past(prbs_error_i))
    );

endmodule

// ==== rtl/prbs_link_top.sv ====
`timescale 1ns/10ps

module prbs_link_top (
    input  logic                      clk40,
    input  logic                      PRBS_reset,
    input  prbs_link_pkg::ccb_rx_t    ccb_rx_i,
    input  logic                      inject_i,
    input  prbs_link_pkg::lane_mask_t tx_reset_done_i,
    input  prbs_link_pkg::lane_mask_t rx_reset_done_i,
    input  prbs_link_pkg::lane_mask_t prbs_error_i,
    output logic                      gtx_tx_reset_o,
    output logic                      gtx_rx_reset_o,
    output logic                      error_inject_o,
    output prbs_link_pkg::led_t       led_o,
    output prbs_link_pkg::lane_mask_t latched_error_o
);

    import prbs_link_pkg::*;

    // Decoded CCB events into the sequencer
    ccb_evt_t   ccb_evt;
    // Sequencer controls to the monitor and the transceiver pins
    boot_ctrl_t boot_ctrl;

    ////////////////////////////////////////////////////////////////////
    // CCB decode, boot sequencer, error monitor
    ////////////////////////////////////////////////////////////////////

    ccb_cmd_decoder u_ccb_dec (
        .clk40      (clk40),
        .PRBS_reset (PRBS_reset),
        .ccb_rx_i   (ccb_rx_i),
        .ccb_evt_o  (ccb_evt)
    );

    link_boot_fsm u_boot_fsm (
        .clk40           (clk40),
        .PRBS_reset      (PRBS_reset),
        .ccb_evt_i       (ccb_evt),
        .inject_i        (inject_i),
        .tx_reset_done_i (tx_reset_done_i),
        .rx_reset_done_i (rx_reset_done_i),
        .boot_ctrl_o     (boot_ctrl)
    );

    prbs_error_monitor u_err_mon (
        .clk40           (clk40),
        .PRBS_reset      (PRBS_reset),
        .boot_ctrl_i     (boot_ctrl),
        .prbs_error_i    (prbs_error_i),
        .latched_error_o (latched_error_o),
        .led_o           (led_o)
    );

    // Transceiver reset and inject lines
    assign gtx_tx_reset_o = boot_ctrl.tx_reset;
    assign gtx_rx_reset_o = boot_ctrl.rx_reset;
    assign error_inject_o = boot_ctrl.error_inject;

endmodule

// ==== verif/tb_prbs_link_top.sv ====
`timescale 1ns/10ps

module tb_prbs_link_top;

    import prbs_link_pkg::*;

    // Random CCB traffic length in the check state
    localparam int CCB_CYCLES = 200;
    // Four times the longest boot with both done delays, plus the CCB test
    localparam int MAX_CYCLES = 4 * (int'(T_CHECK_START) + 2 * 32) + CCB_CYCLES;

    logic       clk40;
    logic       PRBS_reset;
    ccb_rx_t    ccb_rx_i;
    logic       inject_i;
    lane_mask_t tx_reset_done_i;
    lane_mask_t rx_reset_done_i;
    lane_mask_t prbs_error_i;
    logic       gtx_tx_reset_o;
    logic       gtx_rx_reset_o;
    logic       error_inject_o;
    led_t       led_o;
    lane_mask_t latched_error_o;

    integer     seed;
    int         cycle_count;

    // Reference model, decoder stage
    logic        m_strobe;
    ccb_cmd_t    m_cmd;
    logic        m_bx0_lvl;
    logic        m_bx0_prev;
    logic        m_resync;
    logic        m_bxreset;
    // Reference model, sequencer and latch
    boot_state_t m_state;
    timer_t      m_timer;
    lane_mask_t  m_latch;
    // Expected and observed values of the current cycle
    boot_ctrl_t  exp_ctrl;
    boot_ctrl_t  got_ctrl;
    led_t        exp_led;

    prbs_link_top u_dut (
        .clk40           (clk40),
        .PRBS_reset      (PRBS_reset),
        .ccb_rx_i        (ccb_rx_i),
        .inject_i        (inject_i),
        .tx_reset_done_i (tx_reset_done_i),
        .rx_reset_done_i (rx_reset_done_i),
        .prbs_error_i    (prbs_error_i),
        .gtx_tx_reset_o  (gtx_tx_reset_o),
        .gtx_rx_reset_o  (gtx_rx_reset_o),
        .error_inject_o  (error_inject_o),
        .led_o           (led_o),
        .latched_error_o (latched_error_o)
    );

    initial clk40 = 1'b0;
    always #4 clk40 = ~clk40;

    ////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////

    // Controls as a function of phase and the check-state inputs
    function automatic boot_ctrl_t expect_ctrl(input boot_state_t st, input logic inj,
                                               input logic bx0, input logic bxr);
        boot_ctrl_t c;
        c              = '0;
        c.tx_reset     = (st == ST_RESET);
        c.rx_reset     = st inside {ST_RESET, ST_EN_TX, ST_EN_TX_DONE};
        c.error_inject = (st inside {ST_EN_RX_DONE, ST_PRBS_INJECT, ST_PRBS_INJECT_DONE})
                         || ((st == ST_EN_PRBS_CK) && (inj || bx0));
        c.err_clear    = (st == ST_PRBS_INJECT_DONE) || ((st == ST_EN_PRBS_CK) && bxr);
        c.show_errors  = st inside {ST_PRBS_INJECT, ST_PRBS_INJECT_DONE,
                                    ST_PRBS_INJECT_CLEAR, ST_EN_PRBS_CK};
        case (st)
            ST_EN_TX:             c.phase = PH_EN_TX;
            ST_EN_TX_DONE:        c.phase = PH_TX_DONE;
            ST_EN_RX:             c.phase = PH_EN_RX;
            ST_EN_RX_DONE:        c.phase = PH_RX_DONE;
            ST_PRBS_INJECT:       c.phase = PH_INJECT;
            ST_PRBS_INJECT_DONE:  c.phase = PH_INJECT_DONE;
            ST_PRBS_INJECT_CLEAR: c.phase = PH_INJECT_CLEAR;
            ST_EN_PRBS_CK:        c.phase = PH_CHECK;
            default:              c.phase = PH_RESET;
        endcase
        return c;
    endfunction

    task automatic model_reset();
        m_strobe   = 1'b0;
        m_cmd      = '0;
        m_bx0_lvl  = 1'b0;
        m_bx0_prev = 1'b0;
        m_resync   = 1'b0;
        m_bxreset  = 1'b0;
        m_state    = ST_RESET;
        m_timer    = '0;
        m_latch    = '0;
    endtask

    // One clk40 edge, all terms taken from values before the edge
    task automatic model_step();
        boot_ctrl_t  c;
        logic        leave;
        boot_state_t nxt;
        c = expect_ctrl(m_state, inject_i, m_bx0_lvl & ~m_bx0_prev, m_bxreset);
        if (c.err_clear) begin
            m_latch = '0;
        end else begin
            m_latch = m_latch | prbs_error_i;
        end
        case (m_state)
            ST_RESET:             leave = 1'b1;
            ST_EN_TX:             leave = (m_timer >= T_TX_EN);
            ST_EN_TX_DONE:        leave = &tx_reset_done_i;
            ST_EN_RX:             leave = (m_timer >= T_RX_EN);
            ST_EN_RX_DONE:        leave = &rx_reset_done_i;
            ST_PRBS_INJECT:       leave = (m_timer >= T_INJECT_END);
            ST_PRBS_INJECT_DONE:  leave = (m_timer >= T_CLEAR_START);
            ST_PRBS_INJECT_CLEAR: leave = (m_timer >= T_CHECK_START);
            default:              leave = 1'b0;
        endcase
        // Phases follow the enum order
        nxt = leave ? m_state.next() : m_state;
        if (m_resync) begin
            nxt = ST_RESET;
        end
        if (m_state inside {ST_RESET, ST_EN_TX_DONE, ST_EN_RX_DONE}) begin
            m_timer = '0;
        end else begin
            m_timer = m_timer + 8'd1;
        end
        // Second decode stage uses the previous capture
        m_bx0_prev = m_bx0_lvl;
        m_bx0_lvl  = m_strobe && (m_cmd == CMD_BX0);
        m_resync   = m_strobe && (m_cmd == CMD_RESYNC);
        m_bxreset  = m_strobe && (m_cmd == CMD_BXRESET);
        m_strobe   = ~ccb_rx_i.strobe_n;
        m_cmd      = ~ccb_rx_i.cmd_n;
        m_state    = nxt;
    endtask

    ////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////

    task automatic check_ctrl(input boot_ctrl_t exp, input boot_ctrl_t got);
        string name;
        logic  e;
        logic  g;
        name = "";
        e    = 1'b0;
        g    = 1'b0;
        if (got.error_inject !== exp.error_inject) begin
            name = "error_inject_o";
            e    = exp.error_inject;
            g    = got.error_inject;
        end
        if (got.rx_reset !== exp.rx_reset) begin
            name = "gtx_rx_reset_o";
            e    = exp.rx_reset;
            g    = got.rx_reset;
        end
        if (got.tx_reset !== exp.tx_reset) begin
            name = "gtx_tx_reset_o";
            e    = exp.tx_reset;
            g    = got.tx_reset;
        end
        if (name != "") begin
            $display("MISMATCH t=%0t %s expected=%b actual=%b", $time, name, e, g);
            $display("Simulation FAILED");
            $fatal(1, "reset or inject output differs from the model");
        end
    endtask

    task automatic check_led(input led_t exp, input led_t got);
        if (got !== exp) begin
            $display("MISMATCH t=%0t led_o expected=%h actual=%h", $time, exp, got);
            $display("Simulation FAILED");
            $fatal(1, "LED byte differs from the model");
        end
    endtask

    task automatic check_mask(input lane_mask_t exp, input lane_mask_t got);
        if (got !== exp) begin
            $display("MISMATCH t=%0t latched_error_o expected=%h actual=%h", $time, exp, got);
            $display("Simulation FAILED");
            $fatal(1, "latched error mask differs from the model");
        end
    endtask

    // Model steps on the edge, outputs compared once settled
    always @(posedge clk40) begin
        if (PRBS_reset) begin
            model_reset();
        end else begin
            model_step();
            #1;
            exp_ctrl = expect_ctrl(m_state, inject_i, m_bx0_lvl & ~m_bx0_prev, m_bxreset);
            got_ctrl              = '0;
            got_ctrl.tx_reset     = gtx_tx_reset_o;
            got_ctrl.rx_reset     = gtx_rx_reset_o;
            got_ctrl.error_inject = error_inject_o;
            exp_led = {exp_ctrl.phase, exp_ctrl.show_errors ? m_latch[7:4] : 4'b0000};
            check_ctrl(exp_ctrl, got_ctrl);
            check_led(exp_led, led_o);
            check_mask(m_latch, latched_error_o);
        end
    end

    always @(posedge clk40) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: test sequence still running after %0d cycles", cycle_count);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Stimulus, all driven on the falling edge
    ////////////////////////////////////////////////////////////////////

    task automatic tick();
        logic [31:0] rnd;
        @(negedge clk40);
        rnd          = $random(seed);
        inject_i     = rnd[0] & rnd[1] & rnd[2];
        // Sparse lane errors
        prbs_error_i = rnd[15:8] & rnd[23:16] & rnd[31:24];
    endtask

    task automatic wait_state(input boot_state_t st);
        while (m_state != st) begin
            tick();
        end
    endtask

    // Lanes report done one by one over up to 32 cycles
    task automatic release_done(input logic rx_side);
        logic [31:0] rnd;
        int          delay;
        lane_mask_t  part;
        rnd   = $random(seed);
        delay = int'(rnd[4:0]);
        repeat (delay) begin
            tick();
            rnd  = $random(seed);
            part = rnd[7:0];
            // At least one lane still busy
            part[rnd[10:8]] = 1'b0;
            if (rx_side) begin
                rx_reset_done_i = part;
            end else begin
                tx_reset_done_i = part;
            end
        end
        tick();
        if (rx_side) begin
            rx_reset_done_i = '1;
        end else begin
            tx_reset_done_i = '1;
        end
    endtask

    task automatic run_boot();
        tx_reset_done_i = '0;
        rx_reset_done_i = '0;
        wait_state(ST_EN_TX_DONE);
        release_done(1'b0);
        wait_state(ST_EN_RX_DONE);
        release_done(1'b1);
        wait_state(ST_EN_PRBS_CK);
    endtask

    // Command held for a few cycles, then the bus idles
    task automatic send_ccb(input ccb_cmd_t cmd, input logic strobe, input int hold);
        repeat (hold) begin
            tick();
            ccb_rx_i.strobe_n = ~strobe;
            ccb_rx_i.cmd_n    = ~cmd;
        end
        tick();
        ccb_rx_i = '1;
    endtask

    task automatic ccb_traffic(input int n_cycles);
        logic [31:0] rnd;
        ccb_cmd_t    cmd;
        logic        strobe;
        int          hold;
        int          used;
        used = 0;
        while (used < n_cycles) begin
            rnd = $random(seed);
            case (rnd[1:0])
                2'd0:    cmd = CMD_BX0;
                2'd1:    cmd = CMD_BXRESET;
                2'd2:    cmd = CMD_RESYNC;
                default: cmd = rnd[13:8];
            endcase
            strobe = rnd[4];
            // Resync only unstrobed here
            if (cmd == CMD_RESYNC) begin
                strobe = 1'b0;
            end
            hold = int'(rnd[6:5]) + 1;
            send_ccb(cmd, strobe, hold);
            used = used + hold + 1;
        end
    endtask

    initial begin
        seed            = 32'h6d67_a6a9;
        cycle_count     = 0;
        PRBS_reset      = 1'b1;
        ccb_rx_i        = '1;
        inject_i        = 1'b0;
        tx_reset_done_i = '0;
        rx_reset_done_i = '0;
        prbs_error_i    = '0;
        repeat (8) @(negedge clk40);
        PRBS_reset = 1'b0;

        // Boot order, injection window and error latching
        run_boot();
        ccb_traffic(CCB_CYCLES);

        // Bx-reset with known errors pending
        tick();
        prbs_error_i = 8'hA5;
        send_ccb(CMD_BXRESET, 1'b1, 1);
        repeat (3) begin
            @(negedge clk40);
            prbs_error_i = '0;
            inject_i     = 1'b0;
        end
        check_mask('0, latched_error_o);

        // Resync back to the first phase, then a full second boot
        send_ccb(CMD_RESYNC, 1'b1, 1);
        tick();
        tick();
        check_led({PH_RESET, 4'b0000}, led_o);
        run_boot();
        repeat (10) tick();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== flist.f ====
rtl/prbs_link_pkg.sv
rtl/ccb_cmd_decoder.sv
rtl/link_boot_fsm.sv
rtl/prbs_error_monitor.sv
rtl/prbs_link_top.sv
verif/tb_prbs_link_top.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it, exit status follows the result
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --timescale 1ns/10ps \
        --top-module tb_prbs_link_top -f flist.f -o sim_tb \
    && ./obj_dir/sim_tb \
    || exit 1
